//--- alu_pipe.f
common/core_pkg.sv
common/fwd_if.sv
hw/register_file.sv
decode/forwarding_unit.sv
decode/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/alu_pipe_top.sv
test/tb_checker.sv
test/fwd_assert.sv
test/tb_top.sv

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_TYPE = 7'b0010011
    } opcode_t;

    // Funct3 per operation, shared by R and I forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct7 for R-type
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Operation picked by decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    // Operand source select
    typedef enum logic [1:0] {
        Forward_None     = 2'b00,
        Forward_from_ex  = 2'b01,
        Forward_from_mem = 2'b10
    } forward_sel_t;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fields_t;

    // Same 32 bits, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- common/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Late-stage results routed back to decode
interface fwd_if;

    // Execute stage, ALU output is combinational
    logic [4:0]  rd_ex;
    logic        reg_write_ex;
    logic [31:0] result_ex;

    // Memory stage contents
    logic [4:0]  rd_mem;
    logic        reg_write_mem;
    logic [31:0] result_mem;

    modport ex_src (
        output rd_ex,
        output reg_write_ex,
        output result_ex
    );

    modport mem_src (
        output rd_mem,
        output reg_write_mem,
        output result_mem
    );

    modport fwd_sink (
        input rd_ex,
        input reg_write_ex,
        input result_ex,
        input rd_mem,
        input reg_write_mem,
        input result_mem
    );

endinterface

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instr_valid,
    input  wire instr_u      instr,
    fwd_if.fwd_sink          fwd,
    output logic      [4:0]  raddr1,
    output logic      [4:0]  raddr2,
    input  wire logic [31:0] rdata1,
    input  wire logic [31:0] rdata2,
    output logic             ex_valid,
    output logic      [4:0]  ex_rd,
    output logic             ex_reg_write,
    output alu_op_t          ex_alu_op,
    output logic      [31:0] ex_op_a,
    output logic      [31:0] ex_op_b
);

    // Decode register
    logic   dec_valid;
    instr_u dec_instr;

    // Decoded fields
    alu_op_t      alu_op;
    logic         legal;
    logic         is_rtype;
    logic         is_itype;
    logic [4:0]   rs2_used;
    logic [31:0]  imm;
    forward_sel_t fwd_sel_a;
    forward_sel_t fwd_sel_b;
    logic [31:0]  fwd_a;
    logic [31:0]  fwd_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Payload, qualified by dec_valid
    always_ff @(posedge clk) begin
        dec_instr <= instr;
    end

    ////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////

    always_comb begin
        alu_op   = ALU_ADD;
        legal    = 1'b0;
        is_rtype = 1'b0;
        is_itype = 1'b0;
        case (dec_instr.r.opcode)
            OP_R_TYPE: begin
                is_rtype = 1'b1;
                // SUB is the only alternate funct7
                legal = (dec_instr.r.funct7 == F7_BASE) ||
                        ((dec_instr.r.funct7 == F7_SUB) && (dec_instr.r.funct3 == F3_ADD_SUB));
                case (dec_instr.r.funct3)
                    F3_ADD_SUB: alu_op = (dec_instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL:     alu_op = ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    legal  = 1'b0;
                endcase
            end
            OP_I_TYPE: begin
                is_itype = 1'b1;
                legal    = 1'b1;
                case (dec_instr.i.funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    // Immediate shifts not supported
                    default:    legal  = 1'b0;
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Sign-extended I immediate
    assign imm = {{20{dec_instr.i.imm12[11]}}, dec_instr.i.imm12};

    // I-type has no rs2, present x0 so no hazard is seen
    assign rs2_used = is_rtype ? dec_instr.r.rs2 : 5'd0;

    assign raddr1 = dec_instr.r.rs1;
    assign raddr2 = rs2_used;

    ////////////////////////////////////////
    // Hazard resolution
    ////////////////////////////////////////

    forwarding_unit u_forwarding_unit (
        .rs1_id        (dec_instr.r.rs1),
        .rs2_id        (rs2_used),
        .rd_id_ex      (fwd.rd_ex),
        .rd_id_mem     (fwd.rd_mem),
        .reg_write_ex  (fwd.reg_write_ex),
        .reg_write_mem (fwd.reg_write_mem),
        .forward_rs1   (fwd_sel_a),
        .forward_rs2   (fwd_sel_b)
    );

    function automatic logic [31:0] pick(
        input forward_sel_t sel,
        input logic [31:0]  reg_val,
        input logic [31:0]  ex_val,
        input logic [31:0]  mem_val
    );
        case (sel)
            Forward_from_ex:  return ex_val;
            Forward_from_mem: return mem_val;
            default:          return reg_val;
        endcase
    endfunction

    assign fwd_a = pick(fwd_sel_a, rdata1, fwd.result_ex, fwd.result_mem);
    assign fwd_b = pick(fwd_sel_b, rdata2, fwd.result_ex, fwd.result_mem);

    ////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            // Unknown encodings leave as bubbles
            ex_valid     <= dec_valid && legal;
            ex_reg_write <= dec_valid && legal && (dec_instr.r.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        ex_rd     <= dec_instr.r.rd;
        ex_alu_op <= alu_op;
        ex_op_a   <= fwd_a;
        // Immediate replaces rs2 value
        ex_op_b   <= is_itype ? imm : fwd_b;
    end

endmodule

`default_nettype wire

//--- decode/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import core_pkg::*; (
    input  wire logic [4:0] rs1_id,
    input  wire logic [4:0] rs2_id,
    input  wire logic [4:0] rd_id_ex,
    input  wire logic [4:0] rd_id_mem,
    input  wire logic       reg_write_ex,
    input  wire logic       reg_write_mem,
    output forward_sel_t    forward_rs1,
    output forward_sel_t    forward_rs2
);

    // Per-source hit flags
    logic rs1_hit_ex;
    logic rs1_hit_mem;
    logic rs2_hit_ex;
    logic rs2_hit_mem;

    // Execute match, destination must be a real register
    assign rs1_hit_ex = reg_write_ex && (rd_id_ex != 5'd0) && (rd_id_ex == rs1_id);
    assign rs2_hit_ex = reg_write_ex && (rd_id_ex != 5'd0) && (rd_id_ex == rs2_id);

    // Memory match gated by its own write flag only
    assign rs1_hit_mem = reg_write_mem && (rd_id_mem != 5'd0) && (rd_id_mem == rs1_id);
    assign rs2_hit_mem = reg_write_mem && (rd_id_mem != 5'd0) && (rd_id_mem == rs2_id);

    ////////////////////////////////////////
    // Select, younger result first
    ////////////////////////////////////////

    always_comb begin
        if (rs1_hit_ex) begin
            forward_rs1 = Forward_from_ex;
        end else if (rs1_hit_mem) begin
            forward_rs1 = Forward_from_mem;
        end else begin
            forward_rs1 = Forward_None;
        end
    end

    always_comb begin
        if (rs2_hit_ex) begin
            forward_rs2 = Forward_from_ex;
        end else if (rs2_hit_mem) begin
            forward_rs2 = Forward_from_mem;
        end else begin
            forward_rs2 = Forward_None;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    output logic             wb_valid,
    output logic      [4:0]  wb_rd,
    output logic      [31:0] wb_data
);

    // Register file ports
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;

    // Decode to execute
    logic        ex_valid;
    logic [4:0]  ex_rd;
    logic        ex_reg_write;
    alu_op_t     ex_alu_op;
    logic [31:0] ex_op_a;
    logic [31:0] ex_op_b;

    // Execute to memory
    logic        mem_valid;
    logic [4:0]  mem_rd;
    logic        mem_reg_write;
    logic [31:0] mem_result;

    fwd_if fwd ();

    ////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////

    decode_stage u_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .fwd          (fwd.fwd_sink),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_reg_write (ex_reg_write),
        .ex_alu_op    (ex_alu_op),
        .ex_op_a      (ex_op_a),
        .ex_op_b      (ex_op_b)
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .ex_alu_op     (ex_alu_op),
        .ex_op_a       (ex_op_a),
        .ex_op_b       (ex_op_b),
        .fwd           (fwd.ex_src),
        .mem_valid     (mem_valid),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk           (clk),
        .reset         (reset),
        .mem_valid     (mem_valid),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result),
        .fwd           (fwd.mem_src),
        .we            (we),
        .waddr         (waddr),
        .wdata         (wdata),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    // Shared register storage
    register_file u_register_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        ex_valid,
    input  wire logic [4:0]  ex_rd,
    input  wire logic        ex_reg_write,
    input  wire alu_op_t     ex_alu_op,
    input  wire logic [31:0] ex_op_a,
    input  wire logic [31:0] ex_op_b,
    fwd_if.ex_src            fwd,
    output logic             mem_valid,
    output logic      [4:0]  mem_rd,
    output logic             mem_reg_write,
    output logic      [31:0] mem_result
);

    logic [31:0] alu_result;
    logic [4:0]  shamt;

    // Only the low 5 bits shift
    assign shamt = ex_op_b[4:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        alu_result = '0;
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_op_a + ex_op_b;
            ALU_SUB: alu_result = ex_op_a - ex_op_b;
            ALU_AND: alu_result = ex_op_a & ex_op_b;
            ALU_OR:  alu_result = ex_op_a | ex_op_b;
            ALU_XOR: alu_result = ex_op_a ^ ex_op_b;
            // Signed compare
            ALU_SLT: alu_result = {31'd0, $signed(ex_op_a) < $signed(ex_op_b)};
            ALU_SLL: alu_result = ex_op_a << shamt;
            // Logical right shift
            ALU_SRL: alu_result = ex_op_a >> shamt;
            default: alu_result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Forward source toward decode
    ////////////////////////////////////////

    assign fwd.rd_ex        = ex_rd;
    assign fwd.reg_write_ex = ex_valid && ex_reg_write;
    assign fwd.result_ex    = alu_result;

    ////////////////////////////////////////
    // Execute to memory register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_valid && ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd     <= ex_rd;
        mem_result <= alu_result;
    end

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        mem_valid,
    input  wire logic [4:0]  mem_rd,
    input  wire logic        mem_reg_write,
    input  wire logic [31:0] mem_result,
    fwd_if.mem_src           fwd,
    output logic             we,
    output logic      [4:0]  waddr,
    output logic      [31:0] wdata,
    output logic             wb_valid,
    output logic      [4:0]  wb_rd,
    output logic      [31:0] wb_data
);

    // Memory stage holds the registered ALU result from execute
    logic mem_writes;

    assign mem_writes = mem_valid && mem_reg_write;

    // Memory result back to decode
    assign fwd.rd_mem        = mem_rd;
    assign fwd.reg_write_mem = mem_writes;
    assign fwd.result_mem    = mem_result;

    ////////////////////////////////////////
    // Memory to writeback register
    ////////////////////////////////////////

    // Valid only for real writes
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_writes;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_result;
    end

    // Register file port, written on the next edge
    assign we    = wb_valid;
    assign waddr = wb_rd;
    assign wdata = wb_data;

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  raddr1,
    input  wire logic [4:0]  raddr2,
    output logic      [31:0] rdata1,
    output logic      [31:0] rdata2,
    input  wire logic        we,
    input  wire logic [4:0]  waddr,
    input  wire logic [31:0] wdata
);

    logic [31:0] regs [32];

    // x0 never takes a write
    logic write_en;

    assign write_en = we && (waddr != 5'd0);

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Write-through covers the writeback hazard
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (write_en && (addr == waddr)) begin
            return wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f alu_pipe.f \
    -o alu_pipe_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

# The simulation log decides the result
./obj_dir/alu_pipe_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log && { echo "run passed"; exit 0; } \
    || { echo "run failed"; exit 1; }

//--- test/fwd_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_assert import core_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         wb_valid,
    input  wire logic [4:0]   rs1_id,
    input  wire logic [4:0]   rs2_id,
    input  wire logic [4:0]   rd_id_ex,
    input  wire logic         reg_write_ex,
    input  wire forward_sel_t forward_rs1,
    input  wire forward_sel_t forward_rs2
);

    // Execute source would win for this operand
    logic rs1_ex_match;
    logic rs2_ex_match;

    // Failed assertions so far
    int fail_count = 0;

    assign rs1_ex_match = reg_write_ex && (rd_id_ex != 5'd0) && (rd_id_ex == rs1_id);
    assign rs2_ex_match = reg_write_ex && (rd_id_ex != 5'd0) && (rd_id_ex == rs2_id);

    ////////////////////////////////////////
    // Forward select rules
    ////////////////////////////////////////

    ex_rs1_real_rd: assert property (@(posedge clk) disable iff (reset)
        (forward_rs1 == Forward_from_ex) |-> (rd_id_ex != 5'd0))
        else begin
            fail_count++;
            $error("rs1 forwarded from execute for destination x0");
        end

    ex_rs2_real_rd: assert property (@(posedge clk) disable iff (reset)
        (forward_rs2 == Forward_from_ex) |-> (rd_id_ex != 5'd0))
        else begin
            fail_count++;
            $error("rs2 forwarded from execute for destination x0");
        end

    // Younger result has priority
    mem_rs1_priority: assert property (@(posedge clk) disable iff (reset)
        (forward_rs1 == Forward_from_mem) |-> !rs1_ex_match)
        else begin
            fail_count++;
            $error("rs1 took the memory result over a matching execute result");
        end

    mem_rs2_priority: assert property (@(posedge clk) disable iff (reset)
        (forward_rs2 == Forward_from_mem) |-> !rs2_ex_match)
        else begin
            fail_count++;
            $error("rs2 took the memory result over a matching execute result");
        end

    // Writeback is quiet right after reset
    reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid)
        else begin
            fail_count++;
            $error("wb_valid high in the cycle after reset");
        end

endmodule

bind alu_pipe_top fwd_assert u_fwd_assert (
    .clk          (clk),
    .reset        (reset),
    .wb_valid     (wb_valid),
    .rs1_id       (u_decode_stage.u_forwarding_unit.rs1_id),
    .rs2_id       (u_decode_stage.u_forwarding_unit.rs2_id),
    .rd_id_ex     (u_decode_stage.u_forwarding_unit.rd_id_ex),
    .reg_write_ex (u_decode_stage.u_forwarding_unit.reg_write_ex),
    .forward_rs1  (u_decode_stage.u_forwarding_unit.forward_rs1),
    .forward_rs2  (u_decode_stage.u_forwarding_unit.forward_rs2)
);

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire logic        clk,
    input  wire logic        wb_valid,
    input  wire logic [4:0]  wb_rd,
    input  wire logic [31:0] wb_data,
    input  wire logic        exp_push,
    input  wire logic [7:0]  exp_test,
    input  wire logic [4:0]  exp_rd,
    input  wire logic [31:0] exp_data,
    input  wire logic [31:0] cycle,
    output int               pending,
    output int               errors,
    output int               checked
);

    // Edges from the sampling edge to a visible result
    localparam int LATENCY = 3;

    typedef struct packed {
        logic [7:0]  test;
        logic [4:0]  rd;
        logic [31:0] data;
        int          stamp;
    } exp_t;

    exp_t exp_q [$];
    exp_t head;

    int err_count   = 0;
    int check_count = 0;
    int pend_count  = 0;

    assign pending = pend_count;
    assign errors  = err_count;
    assign checked = check_count;

    ////////////////////////////////////////
    // Compare one writeback
    ////////////////////////////////////////

    task automatic check_result(input exp_t e);
        int bad;
        bad = 0;
        if (wb_rd !== e.rd) begin
            $display("ERR %0t wb_rd expected %0d actual %0d", $time, e.rd, wb_rd);
            bad++;
        end
        if (wb_data !== e.data) begin
            $display("ERR %0t wb_data expected 0x%08h actual 0x%08h",
                     $time, e.data, wb_data);
            bad++;
        end
        // Result must land exactly on its stamped cycle
        if (cycle != e.stamp) begin
            $display("ERR %0t wb_valid cycle expected %0d actual %0d", $time, e.stamp, cycle);
            bad++;
        end
        check_count++;
        err_count += bad;
        if (bad == 0) begin
            $display("test %0d: x%0d = 0x%08h ok", e.test, e.rd, e.data);
        end else begin
            $display("test %0d: x%0d failed", e.test, e.rd);
        end
    endtask

    ////////////////////////////////////////
    // Watch writeback at mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%0t: wb_valid for x%0d while no result was expected", $time, wb_rd);
                err_count++;
            end else begin
                head = exp_q.pop_front();
                check_result(head);
            end
        end
        // Entry driven this cycle is sampled on the next rising edge
        if (exp_push) begin
            head.test  = exp_test;
            head.rd    = exp_rd;
            head.data  = exp_data;
            head.stamp = cycle + 1 + LATENCY;
            exp_q.push_back(head);
        end
        pend_count = exp_q.size();
    end

endmodule

`default_nettype wire

//--- test/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import core_pkg::*; ();

    localparam int DRAIN_LIMIT = 50;
    localparam int SETTLE      = 6;

    // One row of the stimulus table
    typedef struct packed {
        logic [31:0] instr;
        logic        bubble;
        logic        writes;
        logic [7:0]  test;
        logic [4:0]  rd;
        logic [31:0] data;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // Expected write toward the checker
    logic        exp_push;
    logic [7:0]  exp_test;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;

    int cycle = 0;
    int pending;
    int errors;
    int checked;

    integer seed = 46;
    entry_t table_q [$];

    alu_pipe_top DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    tb_checker u_checker (
        .clk      (clk),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .exp_push (exp_push),
        .exp_test (exp_test),
        .exp_rd   (exp_rd),
        .exp_data (exp_data),
        .cycle    (cycle),
        .pending  (pending),
        .errors   (errors),
        .checked  (checked)
    );

    always #2 clk = ~clk;

    // Rising edge count for latency stamps
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////

    function automatic logic [31:0] encode_r(
        input logic [6:0] funct7,
        input logic [2:0] funct3,
        input int         rd,
        input int         rs1,
        input int         rs2
    );
        instr_u w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2[4:0];
        w.r.rs1    = rs1[4:0];
        w.r.funct3 = funct3;
        w.r.rd     = rd[4:0];
        w.r.opcode = OP_R_TYPE;
        return w;
    endfunction

    // Signed immediate keeps its low 12 bits
    function automatic logic [31:0] encode_i(
        input logic [2:0] funct3,
        input int         rd,
        input int         rs1,
        input int         imm
    );
        instr_u w;
        w.i.imm12  = imm[11:0];
        w.i.rs1    = rs1[4:0];
        w.i.funct3 = funct3;
        w.i.rd     = rd[4:0];
        w.i.opcode = OP_I_TYPE;
        return w;
    endfunction

    task automatic push_write(input int test, input logic [31:0] word, input int rd,
                              input int data);
        entry_t e;
        e.instr  = word;
        e.bubble = 1'b0;
        e.writes = 1'b1;
        e.test   = test[7:0];
        e.rd     = rd[4:0];
        e.data   = data;
        table_q.push_back(e);
    endtask

    // No writeback expected from this row
    task automatic push_silent(input int test, input logic [31:0] word, input logic bubble);
        entry_t e;
        e.instr  = word;
        e.bubble = bubble;
        e.writes = 1'b0;
        e.test   = test[7:0];
        e.rd     = '0;
        e.data   = '0;
        table_q.push_back(e);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic build_table();
        int rnd;
        int va;
        int vb;
        rnd = $random(seed);
        va  = {{20{rnd[11]}}, rnd[11:0]};
        rnd = $random(seed);
        vb  = {{20{rnd[11]}}, rnd[11:0]};
        // Back to back uses the execute forward
        push_write(1, encode_i(F3_ADD_SUB, 1, 0, va), 1, va);
        push_write(1, encode_r(F7_BASE, F3_ADD_SUB, 2, 1, 1), 2, va + va);
        // Gaps of one, two and three
        push_write(2, encode_i(F3_ADD_SUB, 4, 0, vb), 4, vb);
        push_write(2, encode_i(F3_ADD_SUB, 5, 0, 100), 5, 100);
        push_write(2, encode_r(F7_BASE, F3_ADD_SUB, 6, 4, 0), 6, vb);
        push_write(2, encode_r(F7_BASE, F3_XOR, 7, 5, 4), 7, 100 ^ vb);
        push_write(2, encode_r(F7_BASE, F3_OR, 8, 4, 5), 8, vb | 100);
        // x3 written twice so the younger value wins
        push_write(3, encode_i(F3_ADD_SUB, 3, 0, 11), 3, 11);
        push_write(3, encode_i(F3_ADD_SUB, 3, 0, 22), 3, 22);
        push_write(3, encode_r(F7_BASE, F3_ADD_SUB, 9, 3, 3), 9, 44);
        // Operands -20 and 37 with shifts by 37 mod 32
        push_write(4, encode_i(F3_ADD_SUB, 10, 0, -20), 10, -20);
        push_write(4, encode_i(F3_ADD_SUB, 11, 0, 37), 11, 37);
        push_write(4, encode_r(F7_SUB, F3_ADD_SUB, 12, 10, 11), 12, -57);
        push_write(4, encode_r(F7_BASE, F3_AND, 13, 10, 11), 13, 36);
        push_write(4, encode_r(F7_BASE, F3_OR, 14, 10, 11), 14, -19);
        push_write(4, encode_r(F7_BASE, F3_XOR, 15, 10, 11), 15, -55);
        push_write(4, encode_r(F7_BASE, F3_SLT, 16, 10, 11), 16, 1);
        push_write(4, encode_r(F7_BASE, F3_SLT, 17, 11, 10), 17, 0);
        push_write(4, encode_r(F7_BASE, F3_SLL, 18, 11, 11), 18, 1184);
        push_write(4, encode_r(F7_BASE, F3_SRL, 19, 10, 11), 19, 32'h07FF_FFFF);
        push_write(4, encode_r(F7_BASE, F3_ADD_SUB, 20, 10, 11), 20, 17);
        push_write(4, encode_i(F3_AND, 21, 10, 240), 21, 224);
        push_write(4, encode_i(F3_OR, 22, 11, -256), 22, 32'hFFFF_FF25);
        push_write(4, encode_i(F3_XOR, 23, 10, -1), 23, 19);
        push_write(4, encode_i(F3_SLT, 24, 10, -19), 24, 1);
        push_write(4, encode_i(F3_SLT, 25, 11, -5), 25, 0);
        push_write(4, encode_i(F3_ADD_SUB, 26, 11, -50), 26, -13);
        // x0 writes, unknown opcode and a bubble stay silent
        push_silent(5, encode_i(F3_ADD_SUB, 0, 0, 55), 1'b0);
        push_write(5, encode_r(F7_BASE, F3_ADD_SUB, 29, 0, 0), 29, 0);
        push_silent(5, encode_r(F7_BASE, F3_ADD_SUB, 0, 10, 11), 1'b0);
        push_write(5, encode_r(F7_BASE, F3_OR, 30, 0, 0), 30, 0);
        push_silent(5, 32'h0000_0D7F, 1'b0);
        push_silent(5, encode_i(F3_ADD_SUB, 28, 0, 1), 1'b1);
        push_write(5, encode_r(F7_BASE, F3_ADD_SUB, 31, 0, 0), 31, 0);
    endtask

    task automatic drive_entry(input entry_t e);
        instr_valid = !e.bubble;
        instr       = e.instr;
        exp_push    = e.writes;
        exp_test    = e.test;
        exp_rd      = e.rd;
        exp_data    = e.data;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int   wait_cycles;
        logic drain_failed;
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        exp_push     = 1'b0;
        exp_test     = '0;
        exp_rd       = '0;
        exp_data     = '0;
        drain_failed = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // One row per cycle just after the edge
        foreach (table_q[i]) begin
            @(posedge clk);
            #1;
            drive_entry(table_q[i]);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        exp_push    = 1'b0;
        wait_cycles = 0;
        while ((pending != 0) && (wait_cycles < DRAIN_LIMIT)) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            $display("Drain timed out after %0d cycles, %0d results never arrived",
                     DRAIN_LIMIT, pending);
            drain_failed = 1'b1;
        end
        // Catch any late stray writeback
        repeat (SETTLE) @(posedge clk);
        $display("%0d results checked, %0d errors, %0d assertion failures",
                 checked, errors, DUT.u_fwd_assert.fail_count);
        if (drain_failed || (errors != 0) || (DUT.u_fwd_assert.fail_count != 0)) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
